//--- design/recovery_cmd_if.sv
// Decoded command handoff; cmd_valid holds until the one-cycle cmd_done pulse
`timescale 1ns/100ps

interface recovery_cmd_if #(
  parameter int unsigned RegBytes = recovery_pkg::DefaultRegBytes
);
  import recovery_pkg::*;

  logic                  cmd_valid;
  logic                  cmd_is_rd;
  rec_cmd_e              cmd_code;
  len_t                  cmd_len;
  logic                  cmd_error;
  logic [RegBytes*8-1:0] cmd_wdata;
  logic                  cmd_done;

  modport rcv (
    output cmd_valid, cmd_is_rd, cmd_code, cmd_len, cmd_error, cmd_wdata,
    input  cmd_done
  );

  modport exe (
    input  cmd_valid, cmd_is_rd, cmd_code, cmd_len, cmd_error, cmd_wdata,
    output cmd_done
  );

endinterface

//--- design/recovery_executor.sv
// Recovery register file; reads always return RegBytes bytes, errored reads repeat the last one
`timescale 1ns/100ps

module recovery_executor #(
  parameter int unsigned RegBytes = recovery_pkg::DefaultRegBytes
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        host_abort_i,
  input  logic        rd_req_i,
  recovery_cmd_if.exe cmd,
  recovery_res_if.exe res
);
  import recovery_pkg::*;

  localparam int unsigned NumRegs = 4;
  localparam int unsigned CntW    = $clog2(RegBytes + 1);

  typedef enum logic [1:0] {
    IDX_PROT_CAP,
    IDX_DEVICE_STATUS,
    IDX_RESET,
    IDX_RECOVERY_CTRL
  } reg_idx_e;

  logic [RegBytes*8-1:0] regs_q [NumRegs];
  logic [RegBytes*8-1:0] prot_cap;
  reg_idx_e              cmd_idx;
  reg_idx_e              rd_idx_q;
  logic                  cmd_done_q;
  logic                  res_valid_q;
  logic                  res_dvalid_q;
  logic [CntW-1:0]       bcnt_q;

  function automatic reg_idx_e code_to_idx(rec_cmd_e code);
    case (code)
      CMD_DEVICE_STATUS: return IDX_DEVICE_STATUS;
      CMD_RESET:         return IDX_RESET;
      CMD_RECOVERY_CTRL: return IDX_RECOVERY_CTRL;
      default:           return IDX_PROT_CAP;
    endcase
  endfunction

  assign prot_cap = (RegBytes*8)'(ProtCapValue);
  assign cmd_idx  = code_to_idx(cmd.cmd_code);

  // Writes and read selects land with the cmd_done pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_done_q <= 1'b0;
      rd_idx_q   <= IDX_PROT_CAP;
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
      regs_q[IDX_PROT_CAP] <= prot_cap;
    end else begin
      cmd_done_q <= cmd.cmd_valid & ~cmd_done_q;
      if (cmd.cmd_valid && !cmd_done_q && !cmd.cmd_error) begin
        if (cmd.cmd_is_rd) begin
          rd_idx_q <= cmd_idx;
        end else if (cmd_idx != IDX_PROT_CAP) begin
          // Short writes only touch the bytes they carry
          for (int i = 0; i < RegBytes; i++) begin
            if (i < cmd.cmd_len) begin
              regs_q[cmd_idx][i*8 +: 8] <= cmd.cmd_wdata[i*8 +: 8];
            end
          end
        end
      end
    end
  end

  // Response side
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_q  <= 1'b0;
      res_dvalid_q <= 1'b0;
      bcnt_q       <= '0;
    end else if (host_abort_i) begin
      res_valid_q  <= 1'b0;
      res_dvalid_q <= 1'b0;
    end else if (rd_req_i) begin
      res_valid_q  <= 1'b1;
      res_dvalid_q <= 1'b0;
      bcnt_q       <= '0;
    end else begin
      if (res.res_valid && res.res_ready) begin
        res_valid_q  <= 1'b0;
        res_dvalid_q <= 1'b1;
      end
      if (res.res_dvalid && res.res_dready) begin
        if (res.res_dlast) begin
          res_dvalid_q <= 1'b0;
        end else begin
          bcnt_q <= bcnt_q + 1'b1;
        end
      end
    end
  end

  assign cmd.cmd_done   = cmd_done_q;
  assign res.res_valid  = res_valid_q;
  assign res.res_len    = len_t'(RegBytes);
  assign res.res_dvalid = res_dvalid_q;
  assign res.res_data   = regs_q[rd_idx_q][bcnt_q*8 +: 8];
  assign res.res_dlast  = (bcnt_q == CntW'(RegBytes - 1));

endmodule

//--- design/recovery_handler.sv
// Recovery handler top; always in recovery mode, host_nack_i and bus_stop_i abort a response
`timescale 1ns/100ps

module recovery_handler #(
  parameter int unsigned RegBytes = recovery_pkg::DefaultRegBytes
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                bus_start_i,
  input  logic                bus_stop_i,
  input  recovery_pkg::byte_t bus_addr_i,
  input  logic                bus_addr_valid_i,
  input  logic                rx_valid_i,
  output logic                rx_ready_o,
  input  recovery_pkg::byte_t rx_data_i,
  output logic                tx_valid_o,
  input  logic                tx_ready_i,
  output recovery_pkg::byte_t tx_data_o,
  input  logic                host_nack_i
);
  import recovery_pkg::*;

  logic  host_abort;
  logic  rd_req;
  logic  rx_pec_load;
  logic  tx_pec_load;
  byte_t rx_pec_data;
  byte_t tx_pec_data;
  byte_t rx_pec_crc;
  byte_t tx_pec_crc;

  recovery_cmd_if #(.RegBytes(RegBytes)) cmd_if ();
  recovery_res_if res_if ();

  assign host_abort = host_nack_i | bus_stop_i;

  // Address byte seeds both CRCs
  assign rx_pec_data = bus_addr_valid_i ? bus_addr_i : rx_data_i;
  assign tx_pec_data = bus_addr_valid_i ? bus_addr_i : tx_data_o;

  recovery_pec rx_pec (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (bus_start_i),
    .init_i  (bus_addr_valid_i),
    .valid_i (rx_pec_load),
    .data_i  (rx_pec_data),
    .crc_o   (rx_pec_crc)
  );

  recovery_pec tx_pec (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (bus_start_i),
    .init_i  (bus_addr_valid_i),
    .valid_i (tx_pec_load),
    .data_i  (tx_pec_data),
    .crc_o   (tx_pec_crc)
  );

  recovery_receiver #(.RegBytes(RegBytes)) receiver_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus_start_i (bus_start_i),
    .bus_stop_i  (bus_stop_i),
    .rx_valid_i  (rx_valid_i),
    .rx_data_i   (rx_data_i),
    .rx_ready_o  (rx_ready_o),
    .pec_crc_i   (rx_pec_crc),
    .pec_load_o  (rx_pec_load),
    .cmd         (cmd_if.rcv)
  );

  recovery_executor #(.RegBytes(RegBytes)) executor_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .host_abort_i (host_abort),
    .rd_req_i     (rd_req),
    .cmd          (cmd_if.exe),
    .res          (res_if.exe)
  );

  recovery_transmitter transmitter_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .bus_addr_i       (bus_addr_i),
    .bus_addr_valid_i (bus_addr_valid_i),
    .host_abort_i     (host_abort),
    .pec_crc_i        (tx_pec_crc),
    .pec_load_o       (tx_pec_load),
    .rd_req_o         (rd_req),
    .res              (res_if.xmt),
    .tx_valid_o       (tx_valid_o),
    .tx_ready_i       (tx_ready_i),
    .tx_data_o        (tx_data_o)
  );

endmodule

//--- design/recovery_pec.sv
// CRC-8 PEC, one byte per cycle; clear_i wins over init_i, result valid one cycle after load
`timescale 1ns/100ps

module recovery_pec (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                clear_i,
  input  logic                init_i,
  input  logic                valid_i,
  input  recovery_pkg::byte_t data_i,
  output recovery_pkg::byte_t crc_o
);
  import recovery_pkg::*;

  byte_t crc_q;

  function automatic byte_t crc8_byte(byte_t crc, byte_t data);
    byte_t c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ((c << 1) ^ PecPoly) : (c << 1);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      crc_q <= '0;
    end else if (init_i) begin
      // Address byte starts a fresh CRC
      crc_q <= crc8_byte(8'h00, data_i);
    end else if (valid_i) begin
      crc_q <= crc8_byte(crc_q, data_i);
    end
  end

  assign crc_o = crc_q;

endmodule

//--- design/recovery_pkg.sv
// Recovery path types and constants; PROT_CAP is fixed and all registers are at most a few bytes
package recovery_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] len_t;

  // Recovery command codes
  typedef enum logic [7:0] {
    CMD_PROT_CAP      = 8'd34,
    CMD_DEVICE_STATUS = 8'd36,
    CMD_RESET         = 8'd37,
    CMD_RECOVERY_CTRL = 8'd38
  } rec_cmd_e;

  // SMBus style PEC, CRC-8 starting from zero
  localparam byte_t PecPoly = 8'h07;

  // Magic "OCP " with byte 0 sent first
  localparam logic [31:0] ProtCapValue = 32'h2050_434F;

  localparam int unsigned DefaultRegBytes = 4;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_CMD,
    RX_LEN_LO,
    RX_LEN_HI,
    RX_DATA,
    RX_PEC,
    RX_DONE
  } rx_state_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_LEN_LO,
    TX_LEN_HI,
    TX_DATA,
    TX_PEC
  } tx_state_e;

endpackage

//--- design/recovery_receiver.sv
// Recovery packet parser; keeps only the first RegBytes data bytes, stop or Sr ends a packet
`timescale 1ns/100ps

module recovery_receiver #(
  parameter int unsigned RegBytes = recovery_pkg::DefaultRegBytes
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                bus_start_i,
  input  logic                bus_stop_i,
  input  logic                rx_valid_i,
  input  recovery_pkg::byte_t rx_data_i,
  output logic                rx_ready_o,
  input  recovery_pkg::byte_t pec_crc_i,
  output logic                pec_load_o,
  recovery_cmd_if.rcv         cmd
);
  import recovery_pkg::*;

  rx_state_e             state_q;
  rx_state_e             state_d;
  logic                  rx_ready_q;
  logic                  err_q;
  logic                  is_rd_q;
  len_t                  cnt_q;
  len_t                  len_q;
  byte_t                 code_q;
  logic [RegBytes*8-1:0] wdata_q;
  logic                  rx_fire;
  logic                  pkt_end;
  logic                  code_known;
  logic                  is_pec_byte;

  assign rx_fire     = rx_valid_i & rx_ready_q;
  assign pkt_end     = (bus_stop_i | bus_start_i) & (state_q != RX_IDLE) & (state_q != RX_DONE);
  assign code_known  = rx_data_i inside {CMD_PROT_CAP, CMD_DEVICE_STATUS, CMD_RESET,
                                         CMD_RECOVERY_CTRL};
  assign is_pec_byte = (state_q == RX_DATA) && (cnt_q == len_q);

  // PEC byte itself is not part of the CRC
  assign pec_load_o = rx_fire & ((state_q inside {RX_CMD, RX_LEN_LO, RX_LEN_HI}) |
                                 ((state_q == RX_DATA) & !is_pec_byte));

  always_comb begin
    state_d = state_q;
    if (pkt_end) begin
      state_d = RX_DONE;
    end else begin
      case (state_q)
        RX_IDLE:   if (bus_start_i) state_d = RX_CMD;
        RX_CMD:    if (rx_fire) state_d = RX_LEN_LO;
        RX_LEN_LO: if (rx_fire) state_d = RX_LEN_HI;
        RX_LEN_HI: if (rx_fire) state_d = RX_DATA;
        RX_DATA:   if (rx_fire && is_pec_byte) state_d = RX_PEC;
        RX_DONE:   if (cmd.cmd_done) state_d = RX_IDLE;
        default:   state_d = state_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= RX_IDLE;
      rx_ready_q <= 1'b0;
      err_q      <= 1'b0;
      is_rd_q    <= 1'b0;
      cnt_q      <= '0;
    end else begin
      state_q    <= state_d;
      rx_ready_q <= (state_d != RX_DONE);
      if (state_q == RX_IDLE && bus_start_i) begin
        err_q   <= 1'b0;
        is_rd_q <= 1'b0;
        cnt_q   <= '0;
      end
      // Command only followed by Sr is a read request
      if (pkt_end) begin
        is_rd_q <= (state_q == RX_LEN_LO);
        if (!(state_q inside {RX_LEN_LO, RX_PEC})) begin
          err_q <= 1'b1;
        end
      end
      if (rx_fire) begin
        case (state_q)
          RX_CMD:    if (!code_known) err_q <= 1'b1;
          RX_LEN_HI: if ({rx_data_i, len_q[7:0]} > RegBytes) err_q <= 1'b1;
          RX_DATA: begin
            if (is_pec_byte) begin
              if (rx_data_i != pec_crc_i) err_q <= 1'b1;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_fire) begin
      case (state_q)
        RX_CMD:    code_q <= rx_data_i;
        RX_LEN_LO: len_q[7:0] <= rx_data_i;
        RX_LEN_HI: len_q[15:8] <= rx_data_i;
        RX_DATA: begin
          if (!is_pec_byte && cnt_q < RegBytes) begin
            wdata_q[cnt_q*8 +: 8] <= rx_data_i;
          end
        end
        default: ;
      endcase
    end
  end

  assign rx_ready_o    = rx_ready_q;
  assign cmd.cmd_valid = (state_q == RX_DONE);
  assign cmd.cmd_is_rd = is_rd_q;
  assign cmd.cmd_code  = rec_cmd_e'(code_q);
  assign cmd.cmd_len   = len_q;
  assign cmd.cmd_error = err_q;
  assign cmd.cmd_wdata = wdata_q;

endmodule

//--- design/recovery_res_if.sv
// Response header and byte stream, both valid/ready; res_dlast flags the final data byte
`timescale 1ns/100ps

interface recovery_res_if;
  import recovery_pkg::*;

  // Header
  logic  res_valid;
  logic  res_ready;
  len_t  res_len;

  // Data bytes
  logic  res_dvalid;
  logic  res_dready;
  byte_t res_data;
  logic  res_dlast;

  modport exe (
    output res_valid, res_len, res_dvalid, res_data, res_dlast,
    input  res_ready, res_dready
  );

  modport xmt (
    input  res_valid, res_len, res_dvalid, res_data, res_dlast,
    output res_ready, res_dready
  );

endinterface

//--- design/recovery_transmitter.sv
// Response serialiser; an abort drops tx_valid_o next cycle and the rest of the response is lost
`timescale 1ns/100ps

module recovery_transmitter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  recovery_pkg::byte_t bus_addr_i,
  input  logic                bus_addr_valid_i,
  input  logic                host_abort_i,
  input  recovery_pkg::byte_t pec_crc_i,
  output logic                pec_load_o,
  output logic                rd_req_o,
  recovery_res_if.xmt         res,
  output logic                tx_valid_o,
  input  logic                tx_ready_i,
  output recovery_pkg::byte_t tx_data_o
);
  import recovery_pkg::*;

  tx_state_e state_q;
  logic      tx_valid_q;
  byte_t     tx_data_q;
  byte_t     len_hi_q;
  logic      last_q;
  logic      tx_fire;
  logic      dfire;

  assign tx_fire  = tx_valid_q & tx_ready_i;
  assign rd_req_o = bus_addr_valid_i & bus_addr_i[0];

  assign res.res_ready  = (state_q == TX_IDLE);
  assign res.res_dready = (state_q == TX_DATA) & !last_q & (!tx_valid_q | tx_fire);
  assign dfire          = res.res_dvalid & res.res_dready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= TX_IDLE;
      tx_valid_q <= 1'b0;
      last_q     <= 1'b0;
    end else if (host_abort_i) begin
      state_q    <= TX_IDLE;
      tx_valid_q <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (res.res_valid) begin
            state_q    <= TX_LEN_LO;
            tx_valid_q <= 1'b1;
          end
        end
        TX_LEN_LO: if (tx_fire) state_q <= TX_LEN_HI;
        TX_LEN_HI: begin
          if (tx_fire) begin
            state_q    <= TX_DATA;
            tx_valid_q <= 1'b0;
            last_q     <= 1'b0;
          end
        end
        TX_DATA: begin
          if (dfire) begin
            tx_valid_q <= 1'b1;
            last_q     <= res.res_dlast;
          end else if (tx_fire) begin
            // After the last data byte the PEC follows without a gap
            tx_valid_q <= last_q;
            if (last_q) state_q <= TX_PEC;
          end
        end
        TX_PEC: begin
          if (tx_fire) begin
            state_q    <= TX_IDLE;
            tx_valid_q <= 1'b0;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE && res.res_valid) begin
      tx_data_q <= res.res_len[7:0];
      len_hi_q  <= res.res_len[15:8];
    end else if (state_q == TX_LEN_LO && tx_fire) begin
      tx_data_q <= len_hi_q;
    end else if (dfire) begin
      tx_data_q <= res.res_data;
    end
  end

  // CRC has settled by the time the PEC state is reached
  assign tx_data_o  = (state_q == TX_PEC) ? pec_crc_i : tx_data_q;
  assign tx_valid_o = tx_valid_q;
  assign pec_load_o = tx_fire;

endmodule

//--- filelist.f
design/recovery_pkg.sv
design/recovery_cmd_if.sv
design/recovery_res_if.sv
design/recovery_pec.sv
design/recovery_receiver.sv
design/recovery_executor.sv
design/recovery_transmitter.sv
design/recovery_handler.sv
tb/recovery_handler_chk.sv
tb/tb_recovery_handler.sv

//--- run.sh
#!/bin/sh
# Build and run the recovery handler testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_recovery_handler \
    -f filelist.f -o tb_recovery_handler; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/tb_recovery_handler 2>&1); then
  echo "$output"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

//--- tb/recovery_handler_chk.sv
// Handshake assertions for recovery_handler; the hold rule assumes no start or address mid-response
`timescale 1ns/100ps

module recovery_handler_chk (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                bus_stop_i,
  input logic                host_nack_i,
  input logic                rx_ready_i,
  input logic                tx_valid_i,
  input logic                tx_ready_i,
  input recovery_pkg::byte_t tx_data_i
);

  int unsigned fail_count = 0;

  // Offered byte holds until taken unless the host aborts
  tx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (tx_valid_i && !tx_ready_i && !host_nack_i && !bus_stop_i) |=>
      (tx_valid_i && $stable(tx_data_i)))
  else begin
    fail_count++;
    $error("tx_valid_o or tx_data_o changed while tx_ready_i was low");
  end

  tx_nack_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_nack_i |=> !tx_valid_i)
  else begin
    fail_count++;
    $error("tx_valid_o still high in the cycle after host_nack_i");
  end

  rx_reset_a: assert property (@(posedge clk_i) !rst_n_i |=> !rx_ready_i)
  else begin
    fail_count++;
    $error("rx_ready_o high while in reset");
  end

endmodule

//--- tb/tb_recovery_handler.sv
// Directed tests at target address 7'h21, one packet at a time; stops at the first error
`timescale 1ns/100ps

module tb_recovery_handler;
  import recovery_pkg::*;

  typedef byte_t byte_q_t[$];

  localparam int unsigned RegBytes       = DefaultRegBytes;
  localparam int unsigned ClkPeriod      = 8;
  // Six tests at roughly 400 cycles each at most
  localparam int unsigned WatchdogCycles = 2500;
  localparam byte_t       WrAddr         = 8'h42;
  localparam byte_t       RdAddr         = 8'h43;
  // "OCP " with byte 0 first
  localparam logic [31:0] ProtCapExp     = {8'h20, 8'h50, 8'h43, 8'h4F};

  logic  clk_i;
  logic  rst_n_i;
  logic  bus_start_i;
  logic  bus_stop_i;
  byte_t bus_addr_i;
  logic  bus_addr_valid_i;
  logic  rx_valid_i;
  logic  rx_ready_o;
  byte_t rx_data_i;
  logic  tx_valid_o;
  logic  tx_ready_i;
  byte_t tx_data_o;
  logic  host_nack_i;

  logic [RegBytes*8-1:0] reg_model [4];

  recovery_handler #(.RegBytes(RegBytes)) recovery_handler_i (.*);

  bind recovery_handler recovery_handler_chk chk_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus_stop_i  (bus_stop_i),
    .host_nack_i (host_nack_i),
    .rx_ready_i  (rx_ready_o),
    .tx_valid_i  (tx_valid_o),
    .tx_ready_i  (tx_ready_i),
    .tx_data_i   (tx_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired, a DUT handshake never completed");
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

  // Bitwise CRC-8 over x^8+x^2+x+1 with the MSB first
  function automatic byte_t crc8_ref(byte_t crc, byte_t data);
    byte_t c;
    logic  fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[7] ^ data[i];
      c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
    end
    return c;
  endfunction

  function automatic int reg_slot(byte_t code);
    case (code)
      CMD_PROT_CAP:      return 0;
      CMD_DEVICE_STATUS: return 1;
      CMD_RESET:         return 2;
      default:           return 3;
    endcase
  endfunction

  function automatic byte_q_t random_bytes(int n);
    byte_q_t q;
    for (int i = 0; i < n; i++) begin
      q.push_back(byte_t'($urandom));
    end
    return q;
  endfunction

  task automatic check_value(input string what, input int got, input int expected);
    assert (got == expected) else begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic bus_event(input bit start, input bit stop, input bit addr_valid,
                           input byte_t addr);
    @(posedge clk_i);
    rx_valid_i <= 1'b0;
    tx_ready_i <= 1'b0;
    if (start) begin
      // New packet only once the receiver has left DONE
      @(negedge clk_i);
      while (!rx_ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    bus_start_i      <= start;
    bus_stop_i       <= stop;
    bus_addr_valid_i <= addr_valid;
    bus_addr_i       <= addr;
    @(posedge clk_i);
    bus_start_i      <= 1'b0;
    bus_stop_i       <= 1'b0;
    bus_addr_valid_i <= 1'b0;
  endtask

  // Returns once the byte is seen accepted; the transfer is on the next rising edge
  task automatic send_rx_byte(input byte_t b);
    @(posedge clk_i);
    rx_valid_i <= 1'b1;
    rx_data_i  <= b;
    @(negedge clk_i);
    while (!rx_ready_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic recv_tx_bytes(input int n, input bit backpressure, output byte_q_t got);
    got = {};
    while (got.size() < n) begin
      @(posedge clk_i);
      tx_ready_i <= backpressure ? (($urandom % 3) != 0) : 1'b1;
      @(negedge clk_i);
      if (tx_valid_o && tx_ready_i) begin
        got.push_back(tx_data_o);
      end
    end
  endtask

  task automatic write_packet(input byte_t code, input byte_q_t data, input bit bad_pec);
    byte_q_t pkt;
    byte_t   crc;
    pkt.push_back(code);
    pkt.push_back(byte_t'(data.size()));
    pkt.push_back(byte_t'(data.size() >> 8));
    foreach (data[i]) begin
      pkt.push_back(data[i]);
    end
    crc = crc8_ref(8'h00, WrAddr);
    foreach (pkt[i]) begin
      crc = crc8_ref(crc, pkt[i]);
    end
    bus_event(1'b1, 1'b0, 1'b0, 8'h00);
    bus_event(1'b0, 1'b0, 1'b1, WrAddr);
    foreach (pkt[i]) begin
      send_rx_byte(pkt[i]);
    end
    send_rx_byte(bad_pec ? ~crc : crc);
    bus_event(1'b0, 1'b1, 1'b0, 8'h00);
    // Only a clean write of at most RegBytes to a writable register lands
    if (!bad_pec && data.size() <= RegBytes && code != CMD_PROT_CAP) begin
      foreach (data[i]) begin
        reg_model[reg_slot(code)][i*8 +: 8] = data[i];
      end
    end
  endtask

  // Command-only write, Sr, read address, then nbytes of the response
  task automatic start_read(input byte_t code, input int nbytes, input bit backpressure,
                            output byte_q_t resp);
    bus_event(1'b1, 1'b0, 1'b0, 8'h00);
    bus_event(1'b0, 1'b0, 1'b1, WrAddr);
    send_rx_byte(code);
    bus_event(1'b1, 1'b0, 1'b0, 8'h00);
    bus_event(1'b0, 1'b0, 1'b1, RdAddr);
    recv_tx_bytes(nbytes, backpressure, resp);
  endtask

  task automatic read_packet(input byte_t code, input bit backpressure, output byte_q_t resp);
    start_read(code, RegBytes + 3, backpressure, resp);
    // The PEC ends the response
    @(negedge clk_i);
    check_true(!tx_valid_o, "tx_valid_o still high after the PEC byte");
    bus_event(1'b0, 1'b1, 1'b0, 8'h00);
  endtask

  task automatic check_response(input byte_t code, input byte_q_t resp);
    byte_q_t               expected;
    byte_t                 crc;
    logic [RegBytes*8-1:0] value;
    value = reg_model[reg_slot(code)];
    expected.push_back(byte_t'(RegBytes));
    expected.push_back(8'h00);
    for (int i = 0; i < RegBytes; i++) begin
      expected.push_back(value[i*8 +: 8]);
    end
    crc = crc8_ref(8'h00, RdAddr);
    foreach (expected[i]) begin
      crc = crc8_ref(crc, expected[i]);
    end
    expected.push_back(crc);
    foreach (expected[i]) begin
      check_value($sformatf("response byte %0d", i), resp[i], expected[i]);
    end
  endtask

  task automatic test_reset_state();
    @(posedge clk_i);
    @(negedge clk_i);
    check_true(!tx_valid_o, "tx_valid_o is high after reset");
    check_true(rx_ready_o, "rx_ready_o is low after reset");
  endtask

  task automatic test_write_read();
    byte_q_t resp;
    write_packet(CMD_DEVICE_STATUS, random_bytes(RegBytes), 1'b0);
    read_packet(CMD_DEVICE_STATUS, 1'b0, resp);
    check_response(CMD_DEVICE_STATUS, resp);
  endtask

  task automatic test_bad_pec();
    byte_q_t resp;
    write_packet(CMD_DEVICE_STATUS, random_bytes(RegBytes), 1'b1);
    read_packet(CMD_DEVICE_STATUS, 1'b0, resp);
    check_response(CMD_DEVICE_STATUS, resp);
  endtask

  task automatic test_prot_cap();
    byte_q_t resp;
    read_packet(CMD_PROT_CAP, 1'b0, resp);
    check_response(CMD_PROT_CAP, resp);
    write_packet(CMD_PROT_CAP, random_bytes(RegBytes), 1'b0);
    read_packet(CMD_PROT_CAP, 1'b0, resp);
    check_response(CMD_PROT_CAP, resp);
    // Over-long write is rejected as a whole
    write_packet(CMD_DEVICE_STATUS, random_bytes(RegBytes + 1), 1'b0);
    read_packet(CMD_DEVICE_STATUS, 1'b0, resp);
    check_response(CMD_DEVICE_STATUS, resp);
  endtask

  task automatic test_backpressure();
    byte_q_t plain;
    byte_q_t slow;
    write_packet(CMD_RECOVERY_CTRL, random_bytes(RegBytes), 1'b0);
    read_packet(CMD_RECOVERY_CTRL, 1'b0, plain);
    check_response(CMD_RECOVERY_CTRL, plain);
    read_packet(CMD_RECOVERY_CTRL, 1'b1, slow);
    foreach (plain[i]) begin
      check_value($sformatf("back-pressure byte %0d", i), slow[i], plain[i]);
    end
  endtask

  task automatic test_host_nack();
    byte_q_t part;
    byte_q_t resp;
    write_packet(CMD_RESET, random_bytes(RegBytes), 1'b0);
    start_read(CMD_RESET, 3, 1'b0, part);
    @(posedge clk_i);
    host_nack_i <= 1'b1;
    tx_ready_i  <= 1'b0;
    @(posedge clk_i);
    host_nack_i <= 1'b0;
    @(negedge clk_i);
    check_true(!tx_valid_o, "tx_valid_o stayed high after a host NACK");
    bus_event(1'b0, 1'b1, 1'b0, 8'h00);
    read_packet(CMD_RESET, 1'b0, resp);
    check_response(CMD_RESET, resp);
  endtask

  initial begin
    void'($urandom(32'h2b30));
    rst_n_i          = 1'b0;
    bus_start_i      = 1'b0;
    bus_stop_i       = 1'b0;
    bus_addr_i       = 8'h00;
    bus_addr_valid_i = 1'b0;
    rx_valid_i       = 1'b0;
    rx_data_i        = 8'h00;
    tx_ready_i       = 1'b0;
    host_nack_i      = 1'b0;
    reg_model[0]     = ProtCapExp;
    for (int i = 1; i < 4; i++) begin
      reg_model[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_reset_state();
    test_write_read();
    test_bad_pec();
    test_prot_cap();
    test_backpressure();
    test_host_nack();

    repeat (4) @(posedge clk_i);
    if (recovery_handler_i.chk_i.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Bound assertions failed %0d times", recovery_handler_i.chk_i.fail_count);
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
